//--- Makefile
# Verilator build and run of the bridge testbench

TOP = tb_mif

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f hdl/*.sv bench/*.sv bench/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

//--- bench/tb_util.svh
// ---------------------------------------
// shared testbench helpers, included inside tb_mif
// lfsr state is global, every bit taken steps it once
// ---------------------------------------
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

logic [31:0] lfsr_q = 32'h9666_9fec;
int          mismatch_cnt = 0;
int          other_cnt = 0;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [63:0] lfsr_bits(input int n);
  logic [63:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++)
  begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    v      = {v[62:0], fb};
  end
  return v;
endfunction

task automatic report_mismatch(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
  mismatch_cnt++;
  $display("Mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
endtask

task automatic report_fail(input string msg);
  other_cnt++;
  $display("Error: %s at %0t", msg, $time);
endtask

`endif

//--- bench/tb_mif.sv
// ---------------------------------------
// random request traffic against a memory model
// memory answers 4 cycles after a command and after the last burst
// ---------------------------------------
`timescale 1ns/1ns

module tb_mif
  import mif_pkg::*;
();

  logic              clk;
  logic              rst;
  logic              i_stb;
  rbus_beat_t        i_pkt;
  logic              o_co_stb;
  mem_cmd_t          o_co;
  logic              o_do_stb;
  mem_wdata_t        o_do;
  logic              i_di_stb;
  logic [MEM_DW-1:0] i_di_data;
  logic              o_stb;
  rbus_beat_t        o_pkt;

  `include "tb_util.svh"

  // reference queues
  mem_cmd_t          exp_co[$];
  mem_wdata_t        exp_do[$];
  logic              exp_last[$];
  rbus_hdr_t         exp_rhdr[$];
  logic [MEM_DW-1:0] exp_rdata[$];
  int                reads_pending = 0;
  int                rsp_left = 0;

  // memory model state
  logic [2:0]        mq_bl[$];
  int                mq_cyc[$];
  int                cyc = 0;
  int                mem_left = 0;
  int                mem_free = 0;

  mem_cmd_t          co_e;
  mem_wdata_t        do_e;
  logic              last_e;
  rbus_hdr_t         hdr_e;
  logic [MEM_DW-1:0] dat_e;

  mif_top dut (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ---------------------------------------
  // memory model
  // ---------------------------------------
  always @(negedge clk)
  begin
    cyc++;
    if (!rst && o_co_stb && (o_co.cmd == CMD_RD))
    begin
      mq_bl.push_back(o_co.bl);
      mq_cyc.push_back(cyc);
    end
    i_di_stb = 1'b0;
    if (mem_left == 0 && mq_bl.size() > 0 && cyc >= mq_cyc[0] + 4 && cyc >= mem_free)
    begin
      mem_left = int'(mq_bl.pop_front()) + 1;
      void'(mq_cyc.pop_front());
    end
    if (mem_left > 0)
    begin
      i_di_stb  = 1'b1;
      i_di_data = lfsr_bits(64);
      exp_rdata.push_back(i_di_data);
      mem_left--;
      if (mem_left == 0)
        mem_free = cyc + 4;   // gap before next burst
    end
  end

  // ---------------------------------------
  // checkers sample outputs at the falling edge
  // ---------------------------------------
  always @(negedge clk)
  begin
    if (rst)
    begin
      assert (!o_co_stb && !o_do_stb && !o_stb)
      else report_fail("strobe active during reset");
    end
    else
    begin
      if (o_co_stb)
      begin
        if (exp_co.size() == 0)
          report_fail("unexpected memory command");
        else
        begin
          co_e = exp_co.pop_front();
          assert (o_co == co_e) else report_mismatch("o_co", 128'(o_co), 128'(co_e));
          if (co_e.cmd == CMD_WR)
          begin
            assert (o_do_stb) else report_fail("write command without last write word");
          end
        end
      end
      if (o_do_stb)
      begin
        if (exp_do.size() == 0)
          report_fail("unexpected write data word");
        else
        begin
          do_e   = exp_do.pop_front();
          last_e = exp_last.pop_front();
          assert (o_do == do_e) else report_mismatch("o_do", 128'(o_do), 128'(do_e));
          assert (o_co_stb == last_e)
          else report_mismatch("o_co_stb", 128'(o_co_stb), 128'(last_e));
        end
      end
      if (o_stb && o_pkt.sof)
      begin
        assert (rsp_left == 0) else report_fail("response header inside a burst");
        if (exp_rhdr.size() == 0)
          report_fail("unexpected response header");
        else
        begin
          hdr_e = exp_rhdr.pop_front();
          assert (o_pkt.word == hdr_e)
          else report_mismatch("o_pkt.word", 128'(o_pkt.word), 128'(hdr_e));
          rsp_left = hdr_e.len ? LONG_BURST : 1;
        end
      end
      else if (o_stb)
      begin
        if (rsp_left == 0 || exp_rdata.size() == 0)
          report_fail("unexpected response data beat");
        else
        begin
          dat_e = exp_rdata.pop_front();
          assert (o_pkt.word == {8'hff, dat_e})
          else report_mismatch("o_pkt.word", 128'(o_pkt.word), 128'({8'hff, dat_e}));
          rsp_left--;
          if (rsp_left == 0)
            reads_pending--;
        end
      end
    end
  end

  // ---------------------------------------
  // stimulus
  // ---------------------------------------
  task automatic send_beat(input logic sof, input logic [RBUS_W-1:0] word);
    @(negedge clk);
    i_stb      = 1'b1;
    i_pkt.sof  = sof;
    i_pkt.word = word;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(negedge clk);
      i_stb = 1'b0;
    end
  endtask

  function automatic rbus_hdr_t rand_hdr(input rbus_op_e op);
    rbus_hdr_t h;
    h.mark = 2'(lfsr_bits(2));
    h.tag  = 30'(lfsr_bits(30));
    h.len  = 1'(lfsr_bits(1));
    h.addr = 36'(lfsr_bits(36));
    h.rsv  = 1'(lfsr_bits(1));
    h.op   = op;
    return h;
  endfunction

  task automatic send_read(input rbus_op_e op);
    rbus_hdr_t h;
    mem_cmd_t  c;
    int        t;
    t = 0;
    while (reads_pending >= HDR_DEPTH && t < 2000)
    begin
      idle(1);
      t++;
    end
    if (t >= 2000)
      report_fail("timeout waiting for read responses to drain");
    h      = rand_hdr(op);
    c.cmd  = CMD_RD;
    c.bl   = (op == OP_RD8) ? 3'd7 : 3'd0;
    c.addr = {h.addr, 3'b000};
    exp_co.push_back(c);
    reads_pending++;
    send_beat(1'b1, h);
    h.mark = 2'b10;
    h.len  = (op == OP_RD8);
    exp_rhdr.push_back(h);
  endtask

  task automatic send_write();
    rbus_hdr_t         h;
    mem_cmd_t          c;
    mem_wdata_t        w;
    logic [7:0]        be;
    int                n;
    h      = rand_hdr(OP_WR);
    n      = h.len ? LONG_BURST : 1;
    c.cmd  = CMD_WR;
    c.bl   = h.len ? 3'd7 : 3'd0;
    c.addr = {h.addr, 3'b000};
    exp_co.push_back(c);
    send_beat(1'b1, h);
    for (int i = 0; i < n; i++)
    begin
      if (lfsr_bits(1) != 0)
        idle(1);   // gap between data words
      be     = 8'(lfsr_bits(8));
      w.data = lfsr_bits(64);
      w.mask = ~be;
      exp_do.push_back(w);
      exp_last.push_back(i == n - 1);
      send_beat(1'b0, {be, w.data});
    end
  endtask

  initial
  begin
    int sel;
    int t;
    rst       = 1'b1;
    i_stb     = 1'b0;
    i_pkt     = '0;
    i_di_stb  = 1'b0;
    i_di_data = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle(3);
    // back to back reads fill the pending queue
    for (int i = 0; i < 20; i++)
      send_read(OP_RD1);
    idle(2);
    for (int i = 0; i < 80; i++)
    begin
      sel = int'(lfsr_bits(3));
      case (sel)
        0, 1:    send_read(OP_RD1);
        2, 3:    send_read(OP_RD8);
        4, 5:    send_write();
        6:       send_beat(1'b1, rand_hdr(OP_UPD));   // ignored opcode
        default: send_beat(1'b0, 72'(lfsr_bits(64)));   // stray beat
      endcase
      idle(int'(lfsr_bits(2)));
    end
    idle(1);
    t = 0;
    while ((reads_pending > 0 || exp_co.size() > 0 || exp_do.size() > 0) && t < 5000)
    begin
      idle(1);
      t++;
    end
    if (t >= 5000)
      report_fail("timeout waiting for outstanding traffic");
    idle(20);
    $display("errors: mismatch %0d, other %0d", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- hdl/mif_hdr_queue.sv
// ---------------------------------------
// pending read headers, 16 deep
// push when full is outside the contract
// ---------------------------------------
`timescale 1ns/1ns

module mif_hdr_queue
  import mif_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_push,
  input  rbus_hdr_t i_hdr,
  input  logic      i_pop,
  output rbus_hdr_t o_hdr,
  output logic      o_empty
);

  rbus_hdr_t            mem [HDR_DEPTH];
  logic [HDR_PTR_W-1:0] wr_ptr;
  logic [HDR_PTR_W-1:0] rd_ptr;
  logic [HDR_PTR_W:0]   count;
  logic [HDR_PTR_W:0]   count_nxt;
  logic                 do_pop;
  logic                 empty_q;

  assign do_pop = i_pop && !empty_q;   // pop on empty is dropped

  always_comb
  begin
    count_nxt = count;
    if (i_push)
    begin
      count_nxt = count_nxt + 1'b1;
    end
    if (do_pop)
    begin
      count_nxt = count_nxt - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (i_push)
    begin
      mem[wr_ptr] <= i_hdr;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      empty_q <= 1'b1;
    end
    else
    begin
      if (i_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count   <= count_nxt;
      empty_q <= (count_nxt == '0);  // flag lags push by one cycle
    end
  end

  assign o_hdr   = mem[rd_ptr];   // head, valid while not empty
  assign o_empty = empty_q;

endmodule

//--- hdl/mif_pkg.sv
// ---------------------------------------
// word formats of the request bus and the memory port
// every width is fixed by the 72-bit bus, nothing here is tunable
// ---------------------------------------
package mif_pkg;

  // ---------------------------------------
  // sizes
  // ---------------------------------------
  localparam int RBUS_W     = 72;   // packet bus word
  localparam int MEM_DW     = 64;   // memory data word
  localparam int MEM_AW     = 39;   // byte address
  localparam int HDR_DEPTH  = 16;   // max reads in flight
  localparam int HDR_PTR_W  = 4;
  localparam int LONG_BURST = 8;

  localparam logic [1:0] RESP_MARK = 2'b10;
  localparam logic [7:0] DATA_MARK = 8'hff;  // byte enables of response data

  // request opcode in the low bits of a header
  typedef enum logic [1:0] {
    OP_RD1 = 2'd0,
    OP_RD8 = 2'd1,
    OP_WR  = 2'd2,
    OP_UPD = 2'd3    // read-modify-write, not handled
  } rbus_op_e;

  typedef enum logic [2:0] {
    CMD_WR = 3'd0,
    CMD_RD = 3'd1
  } mem_cmd_e;

  // ---------------------------------------
  // bus and memory words
  // ---------------------------------------
  typedef struct packed {
    logic              sof;
    logic [RBUS_W-1:0] word;
  } rbus_beat_t;

  // header view of a bus word, msb first
  typedef struct packed {
    logic [1:0]  mark;
    logic [29:0] tag;
    logic        len;    // long burst
    logic [35:0] addr;   // 8-byte word address
    logic        rsv;
    rbus_op_e    op;
  } rbus_hdr_t;

  typedef struct packed {
    mem_cmd_e          cmd;
    logic [2:0]        bl;     // burst length minus one
    logic [MEM_AW-1:0] addr;
  } mem_cmd_t;

  typedef struct packed {
    logic [7:0]        mask;   // set bit = byte kept
    logic [MEM_DW-1:0] data;
  } mem_wdata_t;

endpackage

//--- hdl/mif_req_ctrl.sv
// ---------------------------------------
// request decoder, one header then 1 or 8 write words
// no back-pressure, memory side always accepts
// a header inside a write packet is taken as data
// ---------------------------------------
`timescale 1ns/1ns

module mif_req_ctrl
  import mif_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       i_stb,
  input  rbus_beat_t i_pkt,
  output logic       o_co_stb,
  output mem_cmd_t   o_co,
  output logic       o_do_stb,
  output mem_wdata_t o_do,
  output logic       o_hq_push,
  output rbus_hdr_t  o_hq_hdr
);

  typedef enum logic {
    ST_IDLE,
    ST_WR_BURST
  } state_e;

  state_e     state;
  logic [3:0] wr_left;      // words still to come in the write burst

  rbus_hdr_t  hdr;
  logic       hdr_stb;
  logic       is_rd;
  logic       is_wr;
  logic       long_burst;
  logic       wr_word;
  logic       last_word;

  // ---------------------------------------
  // header decode
  // ---------------------------------------
  assign hdr     = i_pkt.word;
  assign hdr_stb = i_stb && i_pkt.sof && (state == ST_IDLE);  // stray beats dropped
  assign is_rd   = (hdr.op == OP_RD1) || (hdr.op == OP_RD8);
  assign is_wr   = (hdr.op == OP_WR);

  // reads take length from opcode, writes from len bit
  assign long_burst = is_rd ? (hdr.op == OP_RD8) : hdr.len;

  assign wr_word   = i_stb && (state == ST_WR_BURST);
  assign last_word = wr_word && (wr_left == 4'd1);

  // ---------------------------------------
  // state and word counter
  // ---------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      wr_left <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (hdr_stb && is_wr)
          begin
            state   <= ST_WR_BURST;
            wr_left <= long_burst ? 4'(LONG_BURST) : 4'd1;
          end
        end
        ST_WR_BURST:
        begin
          if (i_stb)
          begin
            wr_left <= wr_left - 4'd1;
            if (wr_left == 4'd1)
            begin
              state <= ST_IDLE;
            end
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------
  // strobes
  // ---------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      o_co_stb  <= 1'b0;
      o_do_stb  <= 1'b0;
      o_hq_push <= 1'b0;
    end
    else
    begin
      o_co_stb  <= (hdr_stb && is_rd) || last_word;  // write cmd goes with last word
      o_do_stb  <= wr_word;
      o_hq_push <= hdr_stb && is_rd;
    end
  end

  // command fields, held through a write burst
  always_ff @(posedge clk)
  begin
    if (hdr_stb && (is_rd || is_wr))
    begin
      o_co.cmd  <= is_rd ? CMD_RD : CMD_WR;
      o_co.bl   <= long_burst ? 3'(LONG_BURST - 1) : 3'd0;
      o_co.addr <= {hdr.addr, 3'b000};
    end
    if (hdr_stb && is_rd)
    begin
      o_hq_hdr <= hdr;   // kept for the response
    end
  end

  // write data path
  always_ff @(posedge clk)
  begin
    if (wr_word)
    begin
      o_do.mask <= ~i_pkt.word[RBUS_W-1:MEM_DW];  // enables to mask
      o_do.data <= i_pkt.word[MEM_DW-1:0];
    end
  end

endmodule

//--- hdl/mif_resp_fmt.sv
// ---------------------------------------
// response builder, header beat then 1 or 8 data beats
// read data must not arrive before the burst state is entered
// ---------------------------------------
`timescale 1ns/1ns

module mif_resp_fmt
  import mif_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_hq_empty,
  input  rbus_hdr_t         i_hq_hdr,
  output logic              o_hq_pop,
  input  logic              i_di_stb,
  input  logic [MEM_DW-1:0] i_di_data,
  output logic              o_stb,
  output rbus_beat_t        o_pkt
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_BURST
  } state_e;

  state_e     state;
  logic [3:0] beats_left;
  logic       rd_long;
  logic       data_beat;
  rbus_hdr_t  resp_hdr;

  assign rd_long   = (i_hq_hdr.op == OP_RD8);
  assign data_beat = i_di_stb && (state == ST_BURST);

  // request header with new mark and len
  always_comb
  begin
    resp_hdr      = i_hq_hdr;
    resp_hdr.mark = RESP_MARK;
    resp_hdr.len  = rd_long;
  end

  // head is consumed on the header cycle
  assign o_hq_pop = (state == ST_HEADER);

  // ---------------------------------------
  // sequencing
  // ---------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= ST_IDLE;
      beats_left <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (!i_hq_empty)
            state <= ST_HEADER;
        end
        ST_HEADER:
        begin
          state      <= ST_BURST;
          beats_left <= rd_long ? 4'(LONG_BURST) : 4'd1;
        end
        ST_BURST:
        begin
          if (i_di_stb)
          begin
            beats_left <= beats_left - 4'd1;
            if (beats_left == 4'd1)
              state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------
  // output beat
  // ---------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      o_stb <= 1'b0;
    else
      o_stb <= (state == ST_HEADER) || data_beat;
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_HEADER)
    begin
      o_pkt.sof  <= 1'b1;
      o_pkt.word <= resp_hdr;
    end
    else if (data_beat)
    begin
      o_pkt.sof  <= 1'b0;
      o_pkt.word <= {DATA_MARK, i_di_data};  // memory data as is
    end
  end

endmodule

//--- hdl/mif_top.sv
// ---------------------------------------
// packet bus to memory controller bridge
// strobe handshakes only, at most 16 reads in flight
// ---------------------------------------
`timescale 1ns/1ns

module mif_top
  import mif_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_stb,
  input  rbus_beat_t        i_pkt,
  output logic              o_co_stb,
  output mem_cmd_t          o_co,
  output logic              o_do_stb,
  output mem_wdata_t        o_do,
  input  logic              i_di_stb,
  input  logic [MEM_DW-1:0] i_di_data,
  output logic              o_stb,
  output rbus_beat_t        o_pkt
);

  // pending read queue links
  logic      hq_push;
  rbus_hdr_t hq_hdr;
  logic      hq_pop;
  rbus_hdr_t hq_hdr_out;
  logic      hq_empty;

  mif_req_ctrl u_req_ctrl (
    .clk       (clk),
    .rst       (rst),
    .i_stb     (i_stb),
    .i_pkt     (i_pkt),
    .o_co_stb  (o_co_stb),
    .o_co      (o_co),
    .o_do_stb  (o_do_stb),
    .o_do      (o_do),
    .o_hq_push (hq_push),
    .o_hq_hdr  (hq_hdr)
  );

  mif_hdr_queue u_hdr_queue (
    .clk     (clk),
    .rst     (rst),
    .i_push  (hq_push),
    .i_hdr   (hq_hdr),
    .i_pop   (hq_pop),
    .o_hdr   (hq_hdr_out),
    .o_empty (hq_empty)
  );

  mif_resp_fmt u_resp_fmt (
    .clk        (clk),
    .rst        (rst),
    .i_hq_empty (hq_empty),
    .i_hq_hdr   (hq_hdr_out),
    .o_hq_pop   (hq_pop),
    .i_di_stb   (i_di_stb),
    .i_di_data  (i_di_data),
    .o_stb      (o_stb),
    .o_pkt      (o_pkt)
  );

endmodule

//--- tb.f
+incdir+bench
hdl/mif_pkg.sv
hdl/mif_req_ctrl.sv
hdl/mif_hdr_queue.sv
hdl/mif_resp_fmt.sv
hdl/mif_top.sv
bench/tb_mif.sv
